// ==== Bender.yml ====
package:
  name: pol

sources:
  - files:
      - logic/pol_pkg.sv
      - logic/pol_fifo.sv
      - logic/pol_ctrl.sv
      - logic/pol_job_regs.sv
      - logic/pol_reduce.sv
      - logic/pol_top.sv
  - target: test
    files:
      - testbench/pol_checker.sv
      - testbench/pol_tb.sv

// ==== logic/pol_ctrl.sv ====
// ==============================
// Run controller for the pooling block
// Loads a full command set, then issues one command per window
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_ctrl #(
    parameter int fifo_addr_w = 2
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    output logic      cfg_rdy,
    input  wire logic cmd_full,
    input  wire logic cmd_empty,
    output logic      cmd_pop,
    input  wire logic job_active,
    input  wire logic win_end,
    output logic      done
);

    // Index of the final window in a run
    localparam logic [fifo_addr_w:0] last_win = (fifo_addr_w+1)'(2 ** fifo_addr_w - 1);

    pol_pkg::pol_state_e state;
    pol_pkg::pol_state_e next_state;

    // Commands issued and windows finished in this run
    logic [fifo_addr_w:0] issue_cnt;
    logic [fifo_addr_w:0] fin_cnt;
    logic                 run_end;

    assign run_end = win_end && (fin_cnt == last_win);

    // ==============================
    // Phase FSM
    // ==============================
    always_comb begin
        next_state = state;
        unique case (state)
            pol_pkg::st_idle: if (start)    next_state = pol_pkg::st_cfg;
            pol_pkg::st_cfg:  if (cmd_full) next_state = pol_pkg::st_cmp;
            pol_pkg::st_cmp:  if (run_end)  next_state = pol_pkg::st_idle;
            default:                        next_state = pol_pkg::st_idle;
        endcase
    end

    // Accept commands until the FIFO fills
    assign cfg_rdy = (state == pol_pkg::st_cfg) && !cmd_full;

    // One pop per free slot, top bit of issue_cnt marks a full set
    assign cmd_pop = (state == pol_pkg::st_cmp) && !job_active && !cmd_empty &&
                     !issue_cnt[fifo_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pol_pkg::st_idle;
            issue_cnt <= '0;
            fin_cnt   <= '0;
            done      <= 1'b0;
        end else begin
            state <= next_state;
            // Single-cycle pulse after the final result
            done  <= (state == pol_pkg::st_cmp) && run_end;
            if (state == pol_pkg::st_idle && start) begin
                issue_cnt <= '0;
                fin_cnt   <= '0;
            end else begin
                if (cmd_pop) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (win_end) begin
                    fin_cnt <= fin_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pol_fifo.sv ====
// ==============================
// Show-ahead FIFO, payload type set per instance
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_fifo #(
    parameter type payload_t = logic,
    parameter int  addr_w    = 2
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push,
    input  wire logic pop,
    input  payload_t  wdata,
    output payload_t  rdata,
    output logic      empty,
    output logic      full
);

    localparam int depth = 2 ** addr_w;

    // Storage, no reset
    payload_t mem [depth];

    // Pointers carry one wrap bit above the index
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;
    logic            do_push;
    logic            do_pop;

    // Drop push on full and pop on empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Same index, wrap bits tell empty from full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    // Head entry visible without a pop
    assign rdata = mem[rd_ptr[addr_w-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[addr_w-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pol_job_regs.sv ====
// ==============================
// Active command and window element count
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_job_regs (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          load,
    input  pol_pkg::pol_cmd_t  cmd,
    input  wire logic          elem,
    output logic               active,
    output pol_pkg::pol_mode_e mode,
    output logic               first,
    output logic               last,
    output logic               win_end
);

    // Latched command, payload only
    pol_pkg::pol_cmd_t            cmd_q;
    logic [pol_pkg::win_w-1:0]    cnt;
    logic [pol_pkg::win_w-1:0]    last_idx;

    assign mode = cmd_q.mode;

    // Zero length runs as a single element
    assign last_idx = (cmd_q.win_len == '0) ? '0 : cmd_q.win_len - 1'b1;
    assign last     = active && (cnt == last_idx);

    always_ff @(posedge clk) begin
        if (load) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            first   <= 1'b0;
            cnt     <= '0;
            win_end <= 1'b0;
        end else begin
            win_end <= 1'b0;
            if (load) begin
                active <= 1'b1;
                first  <= 1'b1;
                cnt    <= '0;
            end else if (elem && active) begin
                first <= 1'b0;
                if (last) begin
                    // Window closes on this edge
                    active  <= 1'b0;
                    win_end <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pol_pkg.sv ====
// ==============================
// Shared widths, command format and FSM encoding for the pooling block
// Referenced by scoped names from RTL and testbench
// ==============================
`default_nettype none

package pol_pkg;

    // ==============================
    // Widths
    // ==============================
    // Pixel lane width
    localparam int pix_w = 8;
    // Window length field, 1..15, zero read as one
    localparam int win_w = 4;
    // Accumulator lane, holds 15 x 255
    localparam int acc_w = 12;

    // ==============================
    // Types
    // ==============================
    // Lane-wise reduction
    typedef enum logic {
        mode_max = 1'b0,
        mode_sum = 1'b1
    } pol_mode_e;

    // One pooling command as stored in the command FIFO
    typedef struct packed {
        pol_mode_e          mode;
        logic [win_w-1:0]   win_len;
    } pol_cmd_t;

    // Controller phases
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_cfg  = 2'b01,
        st_cmp  = 2'b10
    } pol_state_e;

endpackage

`default_nettype wire

// ==== logic/pol_reduce.sv ====
// ==============================
// Lane-wise max or sum over one window
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_reduce #(
    parameter int num_lanes = 4
) (
    input  wire logic                                             clk,
    input  wire logic                                             rst_n,
    input  wire logic                                             elem,
    input  wire logic                                             first,
    input  wire logic                                             last,
    input  pol_pkg::pol_mode_e                                    mode,
    input  wire logic [num_lanes-1:0][pol_pkg::pix_w-1:0]         px,
    output logic                                                  res_val,
    output logic      [num_lanes-1:0][pol_pkg::acc_w-1:0]         res_data
);

    // Running value per lane
    logic [num_lanes-1:0][pol_pkg::acc_w-1:0] acc;
    logic [num_lanes-1:0][pol_pkg::acc_w-1:0] acc_nxt;

    // ==============================
    // Lane update
    // ==============================
    always_comb begin
        logic [pol_pkg::acc_w-1:0] ext;
        for (int i = 0; i < num_lanes; i++) begin
            // Zero-extend the pixel
            ext = pol_pkg::acc_w'(px[i]);
            if (first) begin
                acc_nxt[i] = ext;
            end else if (mode == pol_pkg::mode_max) begin
                acc_nxt[i] = (ext > acc[i]) ? ext : acc[i];
            end else begin
                // Sized to never wrap at 15 elements
                acc_nxt[i] = acc[i] + ext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (elem) begin
            acc <= acc_nxt;
        end
        if (elem && last) begin
            res_data <= acc_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_val <= 1'b0;
        end else begin
            // Pulse once per closed window
            res_val <= elem && last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pol_top.sv ====
// ==============================
// Pooling block top, command and pixel FIFOs around the reduction path
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_top #(
    parameter int num_lanes   = 4,
    parameter int fifo_addr_w = 2
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     start,
    output logic                                          cfg_rdy,
    input  wire logic                                     cfg_val,
    input  pol_pkg::pol_cmd_t                             cfg_cmd,
    output logic                                          px_rdy,
    input  wire logic                                     px_val,
    input  wire logic [num_lanes-1:0][pol_pkg::pix_w-1:0] px_data,
    output logic                                          res_val,
    output logic      [num_lanes-1:0][pol_pkg::acc_w-1:0] res_data,
    output logic                                          done
);

    // Pixel vector as carried by the pixel FIFO
    typedef logic [num_lanes-1:0][pol_pkg::pix_w-1:0] px_vec_t;

    pol_pkg::pol_cmd_t  cmd_head;
    pol_pkg::pol_mode_e mode;
    px_vec_t            px_head;
    logic               cmd_full;
    logic               cmd_empty;
    logic               cmd_pop;
    logic               px_full;
    logic               px_empty;
    logic               px_pop;
    logic               active;
    logic               first;
    logic               last;
    logic               win_end;

    assign px_rdy = !px_full;

    // Consume one pixel per cycle while a window is open
    assign px_pop = active && !px_empty;

    // ==============================
    // Input FIFOs
    // ==============================
    pol_fifo #(.payload_t(pol_pkg::pol_cmd_t), .addr_w(fifo_addr_w)) u_cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (cfg_val && cfg_rdy),
        .pop   (cmd_pop),
        .wdata (cfg_cmd),
        .rdata (cmd_head),
        .empty (cmd_empty),
        .full  (cmd_full)
    );

    pol_fifo #(.payload_t(px_vec_t), .addr_w(fifo_addr_w)) u_px_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (px_val && px_rdy),
        .pop   (px_pop),
        .wdata (px_data),
        .rdata (px_head),
        .empty (px_empty),
        .full  (px_full)
    );

    // ==============================
    // Control and datapath
    // ==============================
    pol_ctrl #(.fifo_addr_w(fifo_addr_w)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg_rdy    (cfg_rdy),
        .cmd_full   (cmd_full),
        .cmd_empty  (cmd_empty),
        .cmd_pop    (cmd_pop),
        .job_active (active),
        .win_end    (win_end),
        .done       (done)
    );

    pol_job_regs u_job (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (cmd_pop),
        .cmd     (cmd_head),
        .elem    (px_pop),
        .active  (active),
        .mode    (mode),
        .first   (first),
        .last    (last),
        .win_end (win_end)
    );

    pol_reduce #(.num_lanes(num_lanes)) u_reduce (
        .clk      (clk),
        .rst_n    (rst_n),
        .elem     (px_pop),
        .first    (first),
        .last     (last),
        .mode     (mode),
        .px       (px_head),
        .res_val  (res_val),
        .res_data (res_data)
    );

endmodule

`default_nettype wire

// ==== testbench/pol_checker.sv ====
// ==============================
// Monitor on the pooling block ports, checks results and run protocol
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_checker #(
    parameter int num_lanes = 4,
    parameter int run_cmds  = 4,
    parameter int px_depth  = 4
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     start,
    input  wire logic                                     cfg_rdy,
    input  wire logic                                     cfg_val,
    input  wire logic                                     px_rdy,
    input  wire logic                                     px_val,
    input  wire logic                                     res_val,
    input  wire logic [num_lanes-1:0][pol_pkg::acc_w-1:0] res_data,
    input  wire logic                                     done,
    output int                                            val_errs,
    output int                                            proto_errs,
    output int                                            pending
);

    typedef logic [num_lanes-1:0][pol_pkg::acc_w-1:0] res_vec_t;

    // Raw records, tag nibble on top
    logic [51:0] rec [0:127];
    res_vec_t    exp_q[$];
    res_vec_t    exp_v;
    // Pixels per window in command order
    int          len_q[$];

    // Per-run bookkeeping
    logic running;
    logic res_q;
    int   n_acc;
    int   n_res;

    // Pixel FIFO bookkeeping, pushes and pixels of closed windows
    int   n_px;
    int   px_used;
    logic exp_rdy;

    // Expected vectors in command order, tag 3 only
    initial begin
        val_errs   = 0;
        proto_errs = 0;
        $readmemh("testbench/pol_testdata.txt", rec);
        for (int i = 0; i < 128; i++) begin
            if (rec[i][51:48] === 4'h3) begin
                exp_q.push_back(rec[i][num_lanes*pol_pkg::acc_w-1:0]);
            end
            // Zero length counts as one pixel
            if (rec[i][51:48] === 4'h1) begin
                len_q.push_back((rec[i][3:0] == 4'h0) ? 1 : int'(rec[i][3:0]));
            end
        end
        pending = exp_q.size();
    end

    // ==============================
    // Sampled at the rising edge
    // ==============================
    always @(posedge clk) begin
        if (!rst_n) begin
            running = 1'b0;
            res_q   = 1'b0;
            n_acc   = 0;
            n_res   = 0;
            n_px    = 0;
            px_used = 0;
        end else begin
            // Fill level is exact while no window can consume
            if (!running || cfg_rdy) begin
                exp_rdy = (n_px - px_used) < px_depth;
                if (px_rdy !== exp_rdy) begin
                    $display("[ERROR] t=%0t px_rdy expected %b actual %b",
                             $time, exp_rdy, px_rdy);
                    val_errs++;
                end
            end else if (!px_rdy && (n_px - px_used) < px_depth) begin
                $display("%0t: px_rdy is low with free space in the pixel FIFO", $time);
                proto_errs++;
            end
            if (px_val && px_rdy) begin
                n_px++;
            end
            // Ready toward the buffer only inside a run
            if (cfg_rdy && !running) begin
                $display("%0t: cfg_rdy is high outside a run", $time);
                proto_errs++;
            end
            if (cfg_rdy && n_acc >= run_cmds) begin
                $display("%0t: cfg_rdy is still high with the command FIFO full", $time);
                proto_errs++;
            end
            if (cfg_val && cfg_rdy) begin
                n_acc++;
            end
            // Results in command order
            if (res_val) begin
                if (!running || exp_q.size() == 0) begin
                    $display("%0t: result pulse with no result expected", $time);
                    proto_errs++;
                end else begin
                    exp_v = exp_q.pop_front();
                    pending = exp_q.size();
                    n_res++;
                    if (len_q.size() != 0) begin
                        px_used += len_q.pop_front();
                    end
                    if (res_data !== exp_v) begin
                        $display("[ERROR] t=%0t res_data expected %h actual %h",
                                 $time, exp_v, res_data);
                        val_errs++;
                    end
                end
            end
            // Run end, one cycle behind the final result
            if (done) begin
                if (!running) begin
                    $display("%0t: done pulse outside a run", $time);
                    proto_errs++;
                end else begin
                    if (n_acc != run_cmds || n_res != run_cmds) begin
                        $display("%0t: run took %0d commands and gave %0d results, not %0d",
                                 $time, n_acc, n_res, run_cmds);
                        proto_errs++;
                    end
                    if (!res_q) begin
                        $display("%0t: done did not follow the last result by one cycle",
                                 $time);
                        proto_errs++;
                    end
                end
                running = 1'b0;
            end
            if (start && !running && !done) begin
                running = 1'b1;
                n_acc   = 0;
                n_res   = 0;
            end
            res_q = res_val;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/pol_tb.sv ====
// ==============================
// Pooling block testbench, runs taken from the test data file
// Results checked by the monitor, closing report at the end
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pol_tb;

    localparam int num_lanes   = 4;
    localparam int fifo_addr_w = 2;
    localparam int run_cmds    = 2 ** fifo_addr_w;
    localparam int rec_depth   = 128;

    typedef logic [num_lanes-1:0][pol_pkg::pix_w-1:0] px_vec_t;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     start;
    logic                                     cfg_rdy;
    logic                                     cfg_val;
    pol_pkg::pol_cmd_t                        cfg_cmd;
    logic                                     px_rdy;
    logic                                     px_val;
    px_vec_t                                  px_data;
    logic                                     res_val;
    logic [num_lanes-1:0][pol_pkg::acc_w-1:0] res_data;
    logic                                     done;

    // Stimulus split by record tag
    logic [51:0]       rec [0:rec_depth-1];
    pol_pkg::pol_cmd_t cmd_q[$];
    px_vec_t           px_q[$];
    int                run_px[$];
    int                total_px;
    int                val_errs;
    int                proto_errs;
    int                pending;
    int                tb_errs;
    bit                parsed;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    pol_top #(.num_lanes(num_lanes), .fifo_addr_w(fifo_addr_w)) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .cfg_rdy  (cfg_rdy),
        .cfg_val  (cfg_val),
        .cfg_cmd  (cfg_cmd),
        .px_rdy   (px_rdy),
        .px_val   (px_val),
        .px_data  (px_data),
        .res_val  (res_val),
        .res_data (res_data),
        .done     (done)
    );

    pol_checker #(
        .num_lanes (num_lanes),
        .run_cmds  (run_cmds),
        .px_depth  (2 ** fifo_addr_w)
    ) chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg_rdy    (cfg_rdy),
        .cfg_val    (cfg_val),
        .px_rdy     (px_rdy),
        .px_val     (px_val),
        .res_val    (res_val),
        .res_data   (res_data),
        .done       (done),
        .val_errs   (val_errs),
        .proto_errs (proto_errs),
        .pending    (pending)
    );

    // ==============================
    // Stimulus tasks
    // ==============================
    // Tag 1 command, tag 2 pixel, a new run every run_cmds commands
    task automatic load_records();
        int n_cmd;
        n_cmd    = 0;
        total_px = 0;
        $readmemh("testbench/pol_testdata.txt", rec);
        for (int i = 0; i < rec_depth; i++) begin
            if (rec[i][51:48] === 4'h1) begin
                if (n_cmd % run_cmds == 0) begin
                    run_px.push_back(0);
                end
                cmd_q.push_back(rec[i][4:0]);
                n_cmd++;
            end else if (rec[i][51:48] === 4'h2) begin
                px_q.push_back(rec[i][num_lanes*pol_pkg::pix_w-1:0]);
                run_px[run_px.size()-1] = run_px[run_px.size()-1] + 1;
                total_px++;
            end
        end
    endtask

    // Hold the command until an edge with cfg_rdy high
    task automatic push_cmd(input pol_pkg::pol_cmd_t c);
        logic ok;
        ok      = 1'b0;
        cfg_val = 1'b1;
        cfg_cmd = c;
        while (!ok) begin
            ok = cfg_rdy;
            @(posedge clk);
            #1;
        end
        cfg_val = 1'b0;
    endtask

    // Same for a pixel, then a random gap of 0..2 cycles
    task automatic push_px(input px_vec_t v);
        logic ok;
        int   gap;
        ok      = 1'b0;
        px_val  = 1'b1;
        px_data = v;
        while (!ok) begin
            ok = px_rdy;
            @(posedge clk);
            #1;
        end
        px_val = 1'b0;
        gap    = $urandom % 3;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Start pulse, commands and pixels side by side, then wait for done
    task automatic drive_run(input int run);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        fork
            for (int k = 0; k < run_cmds; k++) push_cmd(cmd_q.pop_front());
            for (int k = 0; k < run_px[run]; k++) push_px(px_q.pop_front());
        join
        while (!done) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int seed_val;
        seed_val = $urandom(27);
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg_val  = 1'b0;
        cfg_cmd  = '0;
        px_val   = 1'b0;
        px_data  = '0;
        tb_errs  = 0;
        load_records();
        parsed = 1'b1;
        if (run_px.size() == 0 || cmd_q.size() != run_px.size() * run_cmds) begin
            $display("Test data does not hold whole runs of %0d commands", run_cmds);
            tb_errs++;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // A few idle cycles, cfg_rdy must stay low
        repeat (3) @(posedge clk);
        #1;
        for (int r = 0; r < run_px.size(); r++) begin
            drive_run(r);
        end
        repeat (4) @(posedge clk);
        if (pending != 0) begin
            $display("%0d expected results never arrived", pending);
            tb_errs++;
        end
        $display("Errors: value %0d, protocol %0d, testbench %0d",
                 val_errs, proto_errs, tb_errs);
        if (val_errs + proto_errs + tb_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, scaled to the pixel count
    initial begin
        int limit;
        wait (parsed);
        limit = total_px * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: run not finished after %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/pol_testdata.txt ====
// Columns: one 13-digit hex word, tag digit then 12 payload digits
// Tag 1 command {mode, win_len}, tag 2 pixel lanes 3..0, tag 3 expected lanes 3..0
// Run 1: max 3, sum 2, max 1, max 2
1000000000003
1000000000012
1000000000001
1000000000002
20000128005ff 20000347f0600 2000001810410
30340810060ff
20000ff01800a 20000ff0280f6
31fe003100100
200007e00c301
307e0000c3001
2000005050505 2000003090500
3005009005005
// Run 2: sum 15, max 4, sum 0 read as 1, sum 3
100000000001f
1000000000004
1000000000010
1000000000013
20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff
20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff
20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff 20000ffffffff
3ef1ef1ef1ef1
2000000102030 20000400f1f2f 2000001112131 200003f122200
3040012022031
200009abcdef0
309a0bc0de0f0
2000080808080 2000080808080 200007f0100ff
317f1011001ff

// ==== vlog.f ====
logic/pol_pkg.sv
logic/pol_fifo.sv
logic/pol_ctrl.sv
logic/pol_job_regs.sv
logic/pol_reduce.sv
logic/pol_top.sv
testbench/pol_checker.sv
testbench/pol_tb.sv
